/* compile.f */
source/scope_pkg.sv
source/plot_if.sv
source/scan_if.sv
source/xy_plotter.sv
source/vga_timing.sv
source/frame_mixer.sv
source/xy_scope_top.sv
test/tb_xy_scope.sv

/* run_sim.sh */
#!/bin/sh
# builds the simulation with Verilator, runs it and looks for the pass message
verilator --binary --timing --assert -f compile.f --top-module tb_xy_scope \
  -o sim_xy_scope \
  && ./obj_dir/sim_xy_scope | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* source/frame_mixer.sv */
// frame_mixer module: cell buffer with plot writes, read-and-clear scan port, registered VGA outputs
module frame_mixer (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  plot_if.sink                              plot,
  scan_if.sink                              scan,
  output logic [scope_pkg::color_width-1:0] vga_red,
  output logic [scope_pkg::color_width-1:0] vga_grn,
  output logic [scope_pkg::color_width-1:0] vga_blu,
  output logic                              vga_hsync,
  output logic                              vga_vsync
);

  scope_pkg::cell_t                    fb_mem [scope_pkg::cell_count];
  logic [scope_pkg::cell_count-1:0]    cell_written;
  scope_pkg::cell_addr_t               wr_addr;
  scope_pkg::cell_addr_t               rd_addr;
  scope_pkg::cell_t                    rd_cell;

  assign wr_addr = {plot.y, plot.x};
  assign rd_addr = {scan.v_pos, scan.h_pos};

  always_ff @(posedge pixel_clk) begin
    if (plot.valid) begin
      fb_mem[wr_addr] <= plot.color;
    end
  end

  // a cell counts as lit only while its flag is set
  // write comes last so it wins over the scan clear
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      cell_written <= '0;
    end else begin
      if (scan.active) begin
        cell_written[rd_addr] <= 1'b0;
      end
      if (plot.valid) begin
        cell_written[wr_addr] <= 1'b1;
      end
    end
  end

  // old contents on a same-cell collision
  assign rd_cell = cell_written[rd_addr] ? fb_mem[rd_addr] : '0;

  // one bit per colour drives a full-scale channel
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= ~scope_pkg::sync_active_level;
      vga_vsync <= ~scope_pkg::sync_active_level;
    end else begin
      vga_hsync <= scan.hsync;
      vga_vsync <= scan.vsync;
      if (scan.active) begin
        vga_red <= {scope_pkg::color_width{rd_cell.red}};
        vga_grn <= {scope_pkg::color_width{rd_cell.grn}};
        vga_blu <= {scope_pkg::color_width{rd_cell.blu}};
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
    end
  end

  // guards the address range of the buffer
  a_write_row: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    plot.valid |-> (plot.y < scope_pkg::grid_y_t'(scope_pkg::grid_h)))
    else $error("frame buffer write outside the grid");

endmodule

/* source/plot_if.sv */
// plot_if interface: one plot write from the plotter to the mixer
interface plot_if;

  // one-cycle write pulse, no back-pressure
  logic               valid;
  scope_pkg::grid_x_t x;
  scope_pkg::grid_y_t y;
  scope_pkg::cell_t   color;

  modport source (
    output valid,
    output x,
    output y,
    output color
  );

  // frame mixer side
  modport sink (
    input valid,
    input x,
    input y,
    input color
  );

endinterface

/* source/scan_if.sv */
// scan_if interface: raster position, active flag and sync levels to the mixer
interface scan_if;

  // position is only meaningful while active is high
  scope_pkg::grid_x_t h_pos;
  scope_pkg::grid_y_t v_pos;
  logic               active;
  logic               hsync;
  logic               vsync;

  modport source (
    output h_pos,
    output v_pos,
    output active,
    output hsync,
    output vsync
  );

  // frame mixer side
  modport sink (
    input h_pos,
    input v_pos,
    input active,
    input hsync,
    input vsync
  );

endinterface

/* source/scope_pkg.sv */
// grid, raster timing and ADC constants; coordinate, counter, cell and error count types
package scope_pkg;

  // ADC sample and VGA channel widths
  localparam int adc_width   = 10;
  localparam int color_width = 4;

  // display grid in cells
  localparam int grid_w     = 64;
  localparam int grid_h     = 48;
  localparam int cell_count = grid_w * grid_h;

  // horizontal timing, in pixel clocks
  localparam int h_active = 64;
  localparam int h_front  = 4;
  localparam int h_sync   = 8;
  localparam int h_back   = 4;
  localparam int h_total  = h_active + h_front + h_sync + h_back;

  // vertical timing, in lines
  localparam int v_active = 48;
  localparam int v_front  = 2;
  localparam int v_sync   = 2;
  localparam int v_back   = 2;
  localparam int v_total  = v_active + v_front + v_sync + v_back;

  // both syncs are active low
  localparam logic sync_active_level = 1'b0;

  // grid coordinates
  typedef logic [$clog2(grid_w)-1:0] grid_x_t;
  typedef logic [$clog2(grid_h)-1:0] grid_y_t;

  // frame buffer address, row above column
  typedef logic [$bits(grid_y_t)+$bits(grid_x_t)-1:0] cell_addr_t;

  // raster counters
  typedef logic [$clog2(h_total)-1:0] h_count_t;
  typedef logic [$clog2(v_total)-1:0] v_count_t;

  // one frame buffer cell, one bit per colour
  typedef struct packed {
    logic red;
    logic grn;
    logic blu;
  } cell_t;

  // rejected samples, wraps around
  typedef logic [15:0] error_count_t;

endpackage

/* source/vga_timing.sv */
// vga_timing module: horizontal and vertical counters, scan position, active flag and syncs
module vga_timing (
  input  logic   pixel_clk,
  input  logic   rst_n,
  scan_if.source scan
);

  scope_pkg::h_count_t h_count;
  scope_pkg::v_count_t v_count;
  logic                h_last;
  logic                v_last;
  logic                h_visible;
  logic                v_visible;
  logic                h_in_sync;
  logic                v_in_sync;

  assign h_last = h_count == scope_pkg::h_count_t'(scope_pkg::h_total - 1);
  assign v_last = v_count == scope_pkg::v_count_t'(scope_pkg::v_total - 1);

  // one position per clock, line then frame
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      if (h_last) begin
        h_count <= '0;
        if (v_last) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + 1'b1;
        end
      end else begin
        h_count <= h_count + 1'b1;
      end
    end
  end

  assign h_visible = h_count < scope_pkg::h_count_t'(scope_pkg::h_active);
  assign v_visible = v_count < scope_pkg::v_count_t'(scope_pkg::v_active);

  // sync pulse sits between front and back porch
  assign h_in_sync =
    (h_count >= scope_pkg::h_count_t'(scope_pkg::h_active + scope_pkg::h_front)) &&
    (h_count <  scope_pkg::h_count_t'(scope_pkg::h_active + scope_pkg::h_front +
                                      scope_pkg::h_sync));
  assign v_in_sync =
    (v_count >= scope_pkg::v_count_t'(scope_pkg::v_active + scope_pkg::v_front)) &&
    (v_count <  scope_pkg::v_count_t'(scope_pkg::v_active + scope_pkg::v_front +
                                      scope_pkg::v_sync));

  assign scan.h_pos  = scope_pkg::grid_x_t'(h_count);
  assign scan.v_pos  = scope_pkg::grid_y_t'(v_count);
  assign scan.active = h_visible && v_visible;
  assign scan.hsync  = h_in_sync ? scope_pkg::sync_active_level : ~scope_pkg::sync_active_level;
  assign scan.vsync  = v_in_sync ? scope_pkg::sync_active_level : ~scope_pkg::sync_active_level;

  a_counter_range: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    (h_count < scope_pkg::h_count_t'(scope_pkg::h_total)) &&
    (v_count < scope_pkg::v_count_t'(scope_pkg::v_total)))
    else $error("raster counter beyond line or frame total");

  // Syncs must only ever assert inside blanking.
  a_sync_in_blank: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    scan.active |-> (scan.hsync != scope_pkg::sync_active_level) &&
                    (scan.vsync != scope_pkg::sync_active_level))
    else $error("sync active during active video");

endmodule

/* source/xy_plotter.sv */
// xy_plotter module: ADC sample capture, grid mapping, out-of-grid rejection and error count
module xy_plotter (
  input  logic                            pixel_clk,
  input  logic                            rst_n,
  input  logic [scope_pkg::adc_width-1:0] adc_x,
  input  logic [scope_pkg::adc_width-1:0] adc_y,
  input  logic                            adc_red,
  input  logic                            adc_grn,
  input  logic                            adc_blu,
  input  logic                            sample_strobe,
  plot_if.source                          plot,
  output scope_pkg::error_count_t         sample_errors
);

  // mapped sample, held from the strobe edge
  scope_pkg::grid_x_t col_q;
  scope_pkg::grid_y_t row_q;
  scope_pkg::cell_t   color_q;
  logic               strobe_q;
  logic               in_grid;

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= sample_strobe;
    end
  end

  // upper bits of each coordinate pick the cell
  always_ff @(posedge pixel_clk) begin
    if (sample_strobe) begin
      col_q       <= adc_x[scope_pkg::adc_width-1 -: $bits(scope_pkg::grid_x_t)];
      row_q       <= adc_y[scope_pkg::adc_width-1 -: $bits(scope_pkg::grid_y_t)];
      color_q.red <= adc_red;
      color_q.grn <= adc_grn;
      color_q.blu <= adc_blu;
    end
  end

  // rows 48 to 63 fall below the grid
  assign in_grid = row_q < scope_pkg::grid_y_t'(scope_pkg::grid_h);

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      plot.valid    <= 1'b0;
      sample_errors <= '0;
    end else begin
      plot.valid <= strobe_q && in_grid;
      if (strobe_q && !in_grid) begin
        sample_errors <= sample_errors + 1'b1;
      end
    end
  end

  always_ff @(posedge pixel_clk) begin
    if (strobe_q) begin
      plot.x     <= col_q;
      plot.y     <= row_q;
      plot.color <= color_q;
    end
  end

  a_valid_in_grid: assert property (@(posedge pixel_clk) disable iff (!rst_n)
    plot.valid |-> (plot.y < scope_pkg::grid_y_t'(scope_pkg::grid_h)))
    else $error("plot write issued for a row outside the grid");

endmodule

/* source/xy_scope_top.sv */
// xy_scope_top module: sample plotter and raster timing feeding the frame mixer
module xy_scope_top (
  input  logic                              pixel_clk,
  input  logic                              rst_n,
  input  logic [scope_pkg::adc_width-1:0]   adc_x,
  input  logic [scope_pkg::adc_width-1:0]   adc_y,
  input  logic                              adc_red,
  input  logic                              adc_grn,
  input  logic                              adc_blu,
  input  logic                              sample_strobe,
  output logic [scope_pkg::color_width-1:0] vga_red,
  output logic [scope_pkg::color_width-1:0] vga_grn,
  output logic [scope_pkg::color_width-1:0] vga_blu,
  output logic                              vga_hsync,
  output logic                              vga_vsync,
  output scope_pkg::error_count_t           sample_errors
);

  plot_if u_plot_if ();
  scan_if u_scan_if ();

  xy_plotter u_xy_plotter (
    .pixel_clk    (pixel_clk),
    .rst_n        (rst_n),
    .adc_x        (adc_x),
    .adc_y        (adc_y),
    .adc_red      (adc_red),
    .adc_grn      (adc_grn),
    .adc_blu      (adc_blu),
    .sample_strobe(sample_strobe),
    .plot         (u_plot_if),
    .sample_errors(sample_errors)
  );

  // free-running raster, independent of the samples
  vga_timing u_vga_timing (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .scan     (u_scan_if)
  );

  frame_mixer u_frame_mixer (
    .pixel_clk(pixel_clk),
    .rst_n    (rst_n),
    .plot     (u_plot_if),
    .scan     (u_scan_if),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync)
  );

endmodule

/* test/tb_xy_scope.sv */
// tb_xy_scope testbench: clock, reset, random samples, frame buffer reference model, compare tasks
module tb_xy_scope;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_cycles = 80 * 54;
  localparam int wait_limit = 2 * frame_cycles;

  logic pixel_clk;
  logic rst_n;
  logic [9:0] adc_x;
  logic [9:0] adc_y;
  logic adc_red;
  logic adc_grn;
  logic adc_blu;
  logic sample_strobe;
  logic [3:0] vga_red;
  logic [3:0] vga_grn;
  logic [3:0] vga_blu;
  logic vga_hsync;
  logic vga_vsync;
  scope_pkg::error_count_t sample_errors;

  // model of the frame buffer, row-major
  scope_pkg::cell_t model_grid [64*48];
  scope_pkg::error_count_t model_errors;
  int cyc;
  int error_count;
  integer seed;

  xy_scope_top u_xy_scope_top (
    .pixel_clk    (pixel_clk),
    .rst_n        (rst_n),
    .adc_x        (adc_x),
    .adc_y        (adc_y),
    .adc_red      (adc_red),
    .adc_grn      (adc_grn),
    .adc_blu      (adc_blu),
    .sample_strobe(sample_strobe),
    .vga_red      (vga_red),
    .vga_grn      (vga_grn),
    .vga_blu      (vga_blu),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync),
    .sample_errors(sample_errors)
  );

  always #5 pixel_clk = ~pixel_clk;

  // edges since reset release, equals the raster counter position
  always @(posedge pixel_clk) begin
    if (rst_n) begin
      cyc <= cyc + 1;
    end
  end

  function automatic scope_pkg::cell_t expected_pixel(input int h, input int v);
    if (h < 64 && v < 48) begin
      return model_grid[v*64 + h];
    end
    return '0;
  endfunction

  task automatic check_cell(input scope_pkg::cell_t exp, input scope_pkg::cell_t act,
                            input string name);
    if (exp !== act) begin
      $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_sync(input logic exp, input logic act, input string name);
    if (exp !== act) begin
      $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_count(input scope_pkg::error_count_t exp,
                             input scope_pkg::error_count_t act, input string name);
    if (exp !== act) begin
      $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout: %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  // outputs lag the raster by one cycle
  always @(negedge pixel_clk) begin
    scope_pkg::cell_t act;
    scope_pkg::cell_t exp;
    int pos;
    int h;
    int v;
    act.red = (vga_red == 4'hf);
    act.grn = (vga_grn == 4'hf);
    act.blu = (vga_blu == 4'hf);
    if (cyc == 0) begin
      check_sync(1'b1, vga_hsync, "vga_hsync");
      check_sync(1'b1, vga_vsync, "vga_vsync");
      check_cell('0, act, "vga_rgb");
      check_count('0, sample_errors, "sample_errors");
      if (vga_red != 4'h0 || vga_grn != 4'h0 || vga_blu != 4'h0) begin
        $display("colour channels not zero during reset at %0t", $time);
        error_count++;
      end
    end else begin
      pos = (cyc - 1) % frame_cycles;
      h = pos % 80;
      v = pos / 80;
      exp = expected_pixel(h, v);
      check_cell(exp, act, "vga_rgb");
      check_sync(!(h >= 68 && h <= 75), vga_hsync, "vga_hsync");
      check_sync(!(v == 50 || v == 51), vga_vsync, "vga_vsync");
      // read-and-clear
      if (h < 64 && v < 48) begin
        model_grid[v*64 + h] = '0;
      end
    end
  end

  task automatic wait_for_line(input int line);
    int n;
    n = 0;
    while ((cyc % frame_cycles) / 80 != line) begin
      @(negedge pixel_clk);
      n++;
      if (n > wait_limit) begin
        give_up("raster never reached the requested line");
      end
    end
  endtask

  task automatic drive_sample(input logic [9:0] x, input logic [9:0] y, input logic [2:0] rgb);
    scope_pkg::cell_t c;
    int line;
    int n;
    line = (cyc % frame_cycles) / 80;
    if (line < 48 || line > 52) begin
      $display("sample strobe fell outside vertical blanking at %0t", $time);
      error_count++;
    end
    adc_x = x;
    adc_y = y;
    adc_red = rgb[2];
    adc_grn = rgb[1];
    adc_blu = rgb[0];
    sample_strobe = 1'b1;
    c.red = rgb[2];
    c.grn = rgb[1];
    c.blu = rgb[0];
    if (y[9:4] < 6'd48) begin
      model_grid[int'(y[9:4])*64 + int'(x[9:4])] = c;
    end else begin
      model_errors = model_errors + 16'd1;
    end
    @(negedge pixel_clk);
    sample_strobe = 1'b0;
    @(negedge pixel_clk);
    // count settles two cycles after the strobe edge at the latest
    n = 0;
    while (sample_errors != model_errors) begin
      @(negedge pixel_clk);
      n++;
      if (n > 1) begin
        give_up("sample_errors did not match the model count after the sample");
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    int n;
    seed = 32'hbae8;
    pixel_clk = 1'b0;
    rst_n = 1'b0;
    adc_x = '0;
    adc_y = '0;
    adc_red = 1'b0;
    adc_grn = 1'b0;
    adc_blu = 1'b0;
    sample_strobe = 1'b0;
    cyc = 0;
    error_count = 0;
    model_errors = '0;
    foreach (model_grid[i]) model_grid[i] = '0;
    repeat (4) @(negedge pixel_clk);
    rst_n = 1'b1;

    // in-grid points plus a few rejects during the first blanking
    wait_for_line(48);
    repeat (20) begin
      r = $random(seed);
      drive_sample(r[9:0], r[19:10] % 10'd768, r[22:20]);
    end
    drive_sample(10'd100, 10'd200, 3'b100);
    drive_sample(10'd100, 10'd200, 3'b011);
    repeat (3) begin
      r = $random(seed);
      drive_sample(r[9:0], 10'd768 + {2'b00, r[17:10]}, r[22:20]);
    end

    // frame with points, then an empty one, then rejects only
    wait_for_line(0);
    wait_for_line(48);
    wait_for_line(0);
    wait_for_line(48);
    repeat (4) begin
      r = $random(seed);
      drive_sample(r[9:0], 10'd768 + {2'b00, r[17:10]}, r[22:20]);
    end

    n = 0;
    while (cyc < 5 * frame_cycles + 10) begin
      @(negedge pixel_clk);
      n++;
      if (n > 4 * frame_cycles) begin
        give_up("run did not reach its final frame");
      end
    end
    check_count(model_errors, sample_errors, "sample_errors");
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
